//--- ioPredPkg.sv
// Shared definitions for the I/O predication unit
// Holds the port address map, the port counts, the write credit depth,
// the opcode encoding and the packed structs that cross module borders

package ioPredPkg;

    // ----------------------------------------
    // Address map
    // ----------------------------------------

    // Instruction addresses are 10 bits wide
    localparam int addrWidth = 10;

    // Each window holds four ports, selected by the two low address bits
    localparam int readPortCount = 4;
    localparam int writePortCount = 4;
    localparam int portAddrWidth = 2;

    // First address of each window, aligned to the window size
    localparam logic [addrWidth-1:0] readPortBase = 10'h3F0;
    localparam logic [addrWidth-1:0] writePortBase = 10'h3F8;

    // ----------------------------------------
    // Credits and traceability
    // ----------------------------------------

    // A write sink holds this many words before it must return a credit
    localparam int creditWidth = 2;
    localparam logic [creditWidth-1:0] creditMax = 2'd3;

    // Tag width, carried along so results can be matched to instructions
    localparam int tagWidth = 4;

    // Load reads the source, store writes the destination, move does both
    typedef enum logic [1:0] {
        opNop   = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2,
        opMove  = 2'd3
    } opcode_e;

    // One instruction as seen by the unit, 26 bits
    typedef struct packed {
        opcode_e                op;
        logic [addrWidth-1:0]   srcAddr;
        logic [addrWidth-1:0]   dstAddr;
        logic [tagWidth-1:0]    tag;
    } instr_t;

    // Stage-3 outcome of one instruction, 14 bits
    typedef struct packed {
        logic                       valid;
        logic                       annul;
        logic [tagWidth-1:0]        tag;
        logic [readPortCount-1:0]   readEnable;
        logic [writePortCount-1:0]  writeEnable;
    } predResult_t;

endpackage

//--- ioCheck.sv
// Two-stage port address decoder for one I/O window
// Stage 1 decodes the address, stage 2 looks up the addressed port's state
// Used once for the read window and once for the write window

module ioCheck #(
    parameter logic [ioPredPkg::addrWidth-1:0] portBase = '0,
    // Port state level that means the port can be used
    parameter logic readyLevel = 1'b1
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  access,
    input  logic [ioPredPkg::addrWidth-1:0]       addr,
    input  logic [ioPredPkg::readPortCount-1:0]   portState,
    output logic                                  addrIsIo,
    output logic                                  portBlocked,
    output logic [ioPredPkg::readPortCount-1:0]   portSelect
);

    // Read and write windows have the same number of ports
    logic                                  inWindow;
    logic                                  decodeIo;
    logic [ioPredPkg::readPortCount-1:0]   decodeSelect;
    logic                                  stage1Io;
    logic [ioPredPkg::readPortCount-1:0]   stage1Select;
    logic                                  stage2Io;
    logic [ioPredPkg::readPortCount-1:0]   stage2Select;
    logic                                  selectedState;

    // ----------------------------------------
    // Stage 0 decode
    // ----------------------------------------

    // Upper bits pick the window, the low bits pick the port inside it
    assign inWindow = addr[ioPredPkg::addrWidth-1:ioPredPkg::portAddrWidth]
                      == portBase[ioPredPkg::addrWidth-1:ioPredPkg::portAddrWidth];

    // No access means no port is touched, whatever the address holds
    assign decodeIo = access & inWindow;

    always_comb begin
        decodeSelect = '0;
        decodeSelect[addr[ioPredPkg::portAddrWidth-1:0]] = decodeIo;
    end

    // ----------------------------------------
    // Stage 1 and stage 2 registers
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            stage1Io     <= 1'b0;
            stage1Select <= '0;
            stage2Io     <= 1'b0;
            stage2Select <= '0;
        end else begin
            stage1Io     <= decodeIo;
            stage1Select <= decodeSelect;
            stage2Io     <= stage1Io;
            stage2Select <= stage1Select;
        end
    end

    // The select is one-hot, so an OR of the masked state picks one bit
    assign selectedState = |(stage2Select & portState);

    // Blocked only when an I/O port is really addressed and not ready
    assign portBlocked = stage2Io & (selectedState != readyLevel);
    assign addrIsIo    = stage2Io;
    assign portSelect  = stage2Select;

endmodule

//--- ioReadPredication.sv
// Read side of the predication unit
// Checks the source port for data and drives the stage-3 read enables,
// which stay low whenever the instruction is annulled

module ioReadPredication (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  isRead,
    input  logic [ioPredPkg::addrWidth-1:0]       srcAddr,
    input  logic [ioPredPkg::readPortCount-1:0]   readNotEmpty,
    input  logic                                  ioReady,
    output logic                                  readBlocked,
    output logic [ioPredPkg::readPortCount-1:0]   readEnable
);

    logic [ioPredPkg::readPortCount-1:0]   maskedNotEmpty;
    logic [ioPredPkg::readPortCount-1:0]   portSelect;
    logic                                  addrIsIo;
    logic [ioPredPkg::readPortCount-1:0]   stage3Select;
    logic                                  stage3Io;

    // A port being read in stage 3 has not yet dropped its flag,
    // so treat it as empty for the instruction right behind
    assign maskedNotEmpty = readNotEmpty & ~readEnable;

    ioCheck #(
        .portBase   (ioPredPkg::readPortBase),
        .readyLevel (1'b1)
    ) readCheck_i (
        .clock       (clock),
        .reset       (reset),
        .access      (isRead),
        .addr        (srcAddr),
        .portState   (maskedNotEmpty),
        .addrIsIo    (addrIsIo),
        .portBlocked (readBlocked),
        .portSelect  (portSelect)
    );

    // ----------------------------------------
    // Stage 3 alignment with ioReady
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            stage3Select <= '0;
            stage3Io     <= 1'b0;
        end else begin
            stage3Select <= portSelect;
            stage3Io     <= addrIsIo;
        end
    end

    // Annulled instructions leave the port untouched
    assign readEnable = (ioReady & stage3Io) ? stage3Select : '0;

endmodule

//--- ioWritePredication.sv
// Write side of the predication unit
// Checks the destination port for credit and drives the stage-3 write
// enables, which stay low whenever the instruction is annulled

module ioWritePredication (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  isWrite,
    input  logic [ioPredPkg::addrWidth-1:0]       dstAddr,
    input  logic [ioPredPkg::writePortCount-1:0]  portFull,
    input  logic                                  ioReady,
    output logic                                  writeBlocked,
    output logic [ioPredPkg::writePortCount-1:0]  writeEnable
);

    logic [ioPredPkg::writePortCount-1:0]  portSelect;
    logic                                  addrIsIo;
    logic [ioPredPkg::writePortCount-1:0]  stage3Select;
    logic                                  stage3Io;

    // A write port is ready when it is not full, hence readyLevel of 0
    ioCheck #(
        .portBase   (ioPredPkg::writePortBase),
        .readyLevel (1'b0)
    ) writeCheck_i (
        .clock       (clock),
        .reset       (reset),
        .access      (isWrite),
        .addr        (dstAddr),
        .portState   (portFull),
        .addrIsIo    (addrIsIo),
        .portBlocked (writeBlocked),
        .portSelect  (portSelect)
    );

    // ----------------------------------------
    // Stage 3 alignment with ioReady
    // ----------------------------------------

    // ioReady is only known one stage after the check, so hold the select
    always_ff @(posedge clock) begin
        if (reset) begin
            stage3Select <= '0;
            stage3Io     <= 1'b0;
        end else begin
            stage3Select <= portSelect;
            stage3Io     <= addrIsIo;
        end
    end

    // No credit is spent by an annulled instruction
    assign writeEnable = (ioReady & stage3Io) ? stage3Select : '0;

endmodule

//--- writeCreditTracker.sv
// Credit counters for the write ports
// Each counter spends one credit per committed write and gains one per
// credit returned by the sink, and flags the port full when none is left

module writeCreditTracker (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [ioPredPkg::writePortCount-1:0]  writeEnable,
    input  logic [ioPredPkg::writePortCount-1:0]  creditReturn,
    output logic [ioPredPkg::writePortCount-1:0]  portFull
);

    logic [ioPredPkg::writePortCount-1:0][ioPredPkg::creditWidth-1:0] creditCount;

    // ----------------------------------------
    // Counter update
    // ----------------------------------------

    // Spend and return in the same cycle cancel out
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ioPredPkg::writePortCount; i++) begin
                creditCount[i] <= ioPredPkg::creditMax;
            end
        end else begin
            for (int i = 0; i < ioPredPkg::writePortCount; i++) begin
                case ({writeEnable[i], creditReturn[i]})
                    2'b10: begin
                        if (creditCount[i] != '0) begin
                            creditCount[i] <= creditCount[i] - 1'b1;
                        end
                    end
                    2'b01: begin
                        // A return past the sink's depth is dropped
                        if (creditCount[i] != ioPredPkg::creditMax) begin
                            creditCount[i] <= creditCount[i] + 1'b1;
                        end
                    end
                    default: begin
                        creditCount[i] <= creditCount[i];
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // Full flags
    // ----------------------------------------

    // The last credit counts as gone while its write sits in stage 3,
    // because the counter only drops on the next edge
    always_comb begin
        for (int i = 0; i < ioPredPkg::writePortCount; i++) begin
            portFull[i] = (creditCount[i] == '0)
                          || ((creditCount[i] == 1) && writeEnable[i]);
        end
    end

endmodule

//--- ioControl.sv
// Pipeline control of the predication unit
// Decodes the opcode, carries valid and tag through three stages and makes
// the single registered commit or annul decision

module ioControl (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              instrValid,
    input  ioPredPkg::instr_t                 instr,
    input  logic                              readBlocked,
    input  logic                              writeBlocked,
    output logic                              isRead,
    output logic                              isWrite,
    output logic                              ioReady,
    output logic                              resultValid,
    output logic [ioPredPkg::tagWidth-1:0]    resultTag
);

    // Index n holds the instruction in stage n
    logic [3:1]                             validPipe;
    logic [3:1][ioPredPkg::tagWidth-1:0]    tagPipe;

    // ----------------------------------------
    // Opcode decode
    // ----------------------------------------

    // Gated by valid so an empty slot never selects a port
    assign isRead = instrValid
                    & ((instr.op == ioPredPkg::opLoad) | (instr.op == ioPredPkg::opMove));
    assign isWrite = instrValid
                     & ((instr.op == ioPredPkg::opStore) | (instr.op == ioPredPkg::opMove));

    // ----------------------------------------
    // Stage registers
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[2:1], instrValid};
        end
    end

    // Tags move one stage per clock next to their valid bits
    always_ff @(posedge clock) begin
        tagPipe <= {tagPipe[2:1], instr.tag};
    end

    // Both sides must be ready, or the whole instruction is annulled
    always_ff @(posedge clock) begin
        if (reset) begin
            ioReady <= 1'b0;
        end else begin
            ioReady <= validPipe[2] & ~readBlocked & ~writeBlocked;
        end
    end

    assign resultValid = validPipe[3];
    assign resultTag   = tagPipe[3];

endmodule

//--- ioPredication.sv
// Top level of the I/O predication unit
// Instructions enter every cycle and their result leaves three cycles later
// with the port enables, or annulled when a port is empty or out of credit

module ioPredication (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  instrValid,
    input  ioPredPkg::instr_t                     instr,
    input  logic [ioPredPkg::readPortCount-1:0]   readNotEmpty,
    input  logic [ioPredPkg::writePortCount-1:0]  creditReturn,
    output ioPredPkg::predResult_t                result
);

    logic                                  isRead;
    logic                                  isWrite;
    logic                                  ioReady;
    logic                                  readBlocked;
    logic                                  writeBlocked;
    logic                                  resultValid;
    logic [ioPredPkg::tagWidth-1:0]        resultTag;
    logic [ioPredPkg::readPortCount-1:0]   readEnable;
    logic [ioPredPkg::writePortCount-1:0]  writeEnable;
    logic [ioPredPkg::writePortCount-1:0]  portFull;

    // ----------------------------------------
    // Control
    // ----------------------------------------

    ioControl control_i (
        .clock        (clock),
        .reset        (reset),
        .instrValid   (instrValid),
        .instr        (instr),
        .readBlocked  (readBlocked),
        .writeBlocked (writeBlocked),
        .isRead       (isRead),
        .isWrite      (isWrite),
        .ioReady      (ioReady),
        .resultValid  (resultValid),
        .resultTag    (resultTag)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    ioReadPredication readPred_i (
        .clock        (clock),
        .reset        (reset),
        .isRead       (isRead),
        .srcAddr      (instr.srcAddr),
        .readNotEmpty (readNotEmpty),
        .ioReady      (ioReady),
        .readBlocked  (readBlocked),
        .readEnable   (readEnable)
    );

    ioWritePredication writePred_i (
        .clock        (clock),
        .reset        (reset),
        .isWrite      (isWrite),
        .dstAddr      (instr.dstAddr),
        .portFull     (portFull),
        .ioReady      (ioReady),
        .writeBlocked (writeBlocked),
        .writeEnable  (writeEnable)
    );

    writeCreditTracker credits_i (
        .clock        (clock),
        .reset        (reset),
        .writeEnable  (writeEnable),
        .creditReturn (creditReturn),
        .portFull     (portFull)
    );

    // Annul is the stage-3 readiness turned around
    assign result = '{
        valid:       resultValid,
        annul:       ~ioReady,
        tag:         resultTag,
        readEnable:  readEnable,
        writeEnable: writeEnable
    };

endmodule

//--- clockGen.sv
// Clock and reset source for the testbench
// 10 ns clock period, with reset held high for the first three cycles

module clockGen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Released on a falling edge, in step with the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (3) @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- ioPredicationChk.sv
// Concurrent checks on the pipeline control, bound into ioControl
// They watch the valid pipeline and the registered readiness decision

module ioPredicationChk (
    input logic clock,
    input logic reset,
    input logic instrValid,
    input logic ioReady,
    input logic resultValid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Reset clears every stage, so the first three cycles carry no result
    resultAfterReset: assert property (@(posedge clock) disable iff (reset)
        resultValid |-> !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
        else $error("Result valid within three cycles of reset");

    // Fixed latency of three cycles, one result per instruction
    validLatency: assert property (@(posedge clock) disable iff (reset)
        !$past(reset, 3) |-> resultValid == $past(instrValid, 3))
        else $error("resultValid does not follow instrValid by three cycles");

    // The decision is only ever made for a real instruction in stage 2,
    // which entered the unit three cycles before the decision shows
    readyNeedsValid: assert property (@(posedge clock) disable iff (reset)
        ioReady |-> $past(instrValid, 3))
        else $error("ioReady high without a valid stage-2 instruction");

endmodule

//--- ioPredicationTb.sv
// Directed testbench for the I/O predication unit
// Each test drives instructions and port flags on the falling edge, and every
// result is checked against a cycle model of the annul and credit rules

module ioPredicationTb;
    timeunit 1ns;
    timeprecision 1ps;

    // Cycles spent by each test in turn, drain cycles included
    localparam int testSteps = 13 + 8 + 17 + 10 + 7 + 203;
    localparam int marginSteps = 60;

    logic                                  clock;
    logic                                  reset;
    logic                                  instrValid;
    ioPredPkg::instr_t                     instr;
    logic [ioPredPkg::readPortCount-1:0]   readNotEmpty;
    logic [ioPredPkg::writePortCount-1:0]  creditReturn;
    ioPredPkg::predResult_t                result;

    // Model of the last three issued instructions, oldest at index 2
    logic [2:0]                            pipeValid;
    ioPredPkg::instr_t                     pipeInstr [3];
    // Result that the DUT shows in the current cycle
    ioPredPkg::predResult_t                expected;
    logic [ioPredPkg::creditWidth-1:0]     credits [ioPredPkg::writePortCount];
    // Committed writes seen on the output, per port
    logic [ioPredPkg::creditWidth-1:0]     commits [ioPredPkg::writePortCount];
    int                                    errors;
    int                                    checks;
    int                                    seed;

    clockGen clockGen_i (
        .clock (clock),
        .reset (reset)
    );

    ioPredication dut_i (
        .clock        (clock),
        .reset        (reset),
        .instrValid   (instrValid),
        .instr        (instr),
        .readNotEmpty (readNotEmpty),
        .creditReturn (creditReturn),
        .result       (result)
    );

    bind ioControl ioPredicationChk chk_i (
        .clock       (clock),
        .reset       (reset),
        .instrValid  (instrValid),
        .ioReady     (ioReady),
        .resultValid (resultValid)
    );

    // ----------------------------------------
    // Address and instruction helpers
    // ----------------------------------------

    function automatic logic inWindow(input logic [9:0] addr, input logic [9:0] base);
        return addr[9:2] == base[9:2];
    endfunction

    function automatic logic [9:0] readAddr(input logic [1:0] port);
        return {ioPredPkg::readPortBase[9:2], port};
    endfunction

    function automatic logic [9:0] writeAddr(input logic [1:0] port);
        return {ioPredPkg::writePortBase[9:2], port};
    endfunction

    // About half the addresses land in one of the two windows
    function automatic logic [9:0] randomAddr();
        logic [31:0] r;
        r = $random(seed);
        case (r[3:2])
            2'd0: return readAddr(r[1:0]);
            2'd1: return writeAddr(r[1:0]);
            default: return {1'b0, r[12:4]};
        endcase
    endfunction

    function automatic ioPredPkg::instr_t makeInstr(input ioPredPkg::opcode_e op,
            input logic [9:0] src, input logic [9:0] dst);
        ioPredPkg::instr_t ins;
        logic [31:0] r;
        r = $random(seed);
        ins.op = op;
        ins.srcAddr = src;
        ins.dstAddr = dst;
        ins.tag = r[3:0];
        return ins;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Decision for the instruction now in stage 2, made from this cycle's flags
    function automatic ioPredPkg::predResult_t predict(input logic valid,
            input ioPredPkg::instr_t ins, input logic [3:0] notEmpty);
        ioPredPkg::predResult_t r;
        logic [1:0] rp;
        logic [1:0] wp;
        logic doRead;
        logic doWrite;
        logic readOk;
        logic writeOk;
        rp = ins.srcAddr[1:0];
        wp = ins.dstAddr[1:0];
        doRead = (ins.op == ioPredPkg::opLoad || ins.op == ioPredPkg::opMove)
                 && inWindow(ins.srcAddr, ioPredPkg::readPortBase);
        doWrite = (ins.op == ioPredPkg::opStore || ins.op == ioPredPkg::opMove)
                  && inWindow(ins.dstAddr, ioPredPkg::writePortBase);
        // A port read in stage 3 right now counts as empty
        readOk = notEmpty[rp] && !expected.readEnable[rp];
        // The last credit is spoken for while a write to the port sits in stage 3
        writeOk = !(credits[wp] == 2'd0 || (credits[wp] == 2'd1 && expected.writeEnable[wp]));
        r = '0;
        r.valid = valid;
        r.tag = ins.tag;
        r.annul = !(valid && (!doRead || readOk) && (!doWrite || writeOk));
        if (!r.annul && doRead) begin
            r.readEnable[rp] = 1'b1;
        end
        if (!r.annul && doWrite) begin
            r.writeEnable[wp] = 1'b1;
        end
        return r;
    endfunction

    // Credits move on the edge after the write or the return
    task automatic updateCredits(input logic [3:0] returns);
        for (int p = 0; p < ioPredPkg::writePortCount; p++) begin
            if (expected.writeEnable[p] && !returns[p] && credits[p] != 2'd0) begin
                credits[p] = credits[p] - 1'b1;
            end else if (returns[p] && !expected.writeEnable[p]
                         && credits[p] != ioPredPkg::creditMax) begin
                credits[p] = credits[p] + 1'b1;
            end
        end
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    task automatic compareResult(input ioPredPkg::predResult_t want);
        logic tagBad;
        checks++;
        // Tags of empty slots carry no meaning
        tagBad = want.valid && (result.tag !== want.tag);
        if (result.valid !== want.valid || result.annul !== want.annul || tagBad
            || result.readEnable !== want.readEnable
            || result.writeEnable !== want.writeEnable) begin
            errors++;
            $write("MISMATCH at %0t: result v%b a%b tag %h rd %b wr %b", $time, result.valid,
                   result.annul, result.tag, result.readEnable, result.writeEnable);
            $display(", expected v%b a%b tag %h rd %b wr %b", want.valid, want.annul,
                     want.tag, want.readEnable, want.writeEnable);
        end
    endtask

    task automatic compareCredits(input logic [1:0] port,
            input logic [ioPredPkg::creditWidth-1:0] got,
            input logic [ioPredPkg::creditWidth-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t: write port %0d committed %0d writes, expected %0d",
                     $time, port, got, want);
        end
    endtask

    // ----------------------------------------
    // Cycle driver
    // ----------------------------------------

    // One clock cycle, entered and left on a falling edge
    task automatic step(input logic valid, input ioPredPkg::instr_t ins,
            input logic [3:0] notEmpty, input logic [3:0] returns);
        ioPredPkg::predResult_t next;
        // The output belongs to the instruction issued three cycles ago
        compareResult(expected);
        for (int p = 0; p < ioPredPkg::writePortCount; p++) begin
            if (result.valid && result.writeEnable[p]) begin
                commits[p] = commits[p] + 1'b1;
            end
        end
        instrValid = valid;
        instr = ins;
        readNotEmpty = notEmpty;
        creditReturn = returns;
        pipeValid = {pipeValid[1:0], valid};
        pipeInstr[2] = pipeInstr[1];
        pipeInstr[1] = pipeInstr[0];
        pipeInstr[0] = ins;
        next = predict(pipeValid[2], pipeInstr[2], notEmpty);
        updateCredits(returns);
        expected = next;
        @(negedge clock);
    endtask

    task automatic idle(input int count, input logic [3:0] notEmpty,
            input logic [3:0] returns);
        repeat (count) step(1'b0, '0, notEmpty, returns);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    // Nothing is read even with every read port empty
    task automatic nonIoTest();
        logic [31:0] r;
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            if (i < 5) begin
                step(1'b1, makeInstr(ioPredPkg::opcode_e'(r[1:0]), {1'b0, r[10:2]},
                     {1'b0, r[19:11]}), 4'h0, 4'h0);
            end else begin
                step(1'b1, makeInstr(ioPredPkg::opNop, readAddr(r[1:0]),
                     writeAddr(r[3:2])), 4'h0, 4'h0);
            end
        end
        idle(3, 4'h0, 4'h0);
    endtask

    task automatic loadTest();
        for (int p = 0; p < ioPredPkg::readPortCount; p++) begin
            step(1'b1, makeInstr(ioPredPkg::opLoad, readAddr(p[1:0]), 10'h0), 4'hF, 4'h0);
        end
        // Port 2 runs empty from the next cycle on, before the last load is decided
        step(1'b1, makeInstr(ioPredPkg::opLoad, readAddr(2'd2), 10'h0), 4'hF, 4'h0);
        idle(3, 4'b1011, 4'h0);
    endtask

    task automatic storeTest();
        commits[2] = '0;
        repeat (5) step(1'b1, makeInstr(ioPredPkg::opStore, 10'h0, writeAddr(2'd2)),
                        4'hF, 4'h0);
        idle(3, 4'hF, 4'h0);
        compareCredits(2'd2, commits[2], ioPredPkg::creditMax);
        commits[2] = '0;
        idle(1, 4'hF, 4'b0100);
        repeat (2) step(1'b1, makeInstr(ioPredPkg::opStore, 10'h0, writeAddr(2'd2)),
                        4'hF, 4'h0);
        idle(3, 4'hF, 4'h0);
        compareCredits(2'd2, commits[2], 2'd1);
        // Sink drains, so port 2 is back to full depth
        idle(3, 4'hF, 4'b0100);
    endtask

    // The move finds port 0 out of credit and must not read port 1 either
    task automatic moveTest();
        commits[0] = '0;
        repeat (3) step(1'b1, makeInstr(ioPredPkg::opStore, 10'h0, writeAddr(2'd0)),
                        4'hF, 4'h0);
        step(1'b1, makeInstr(ioPredPkg::opMove, readAddr(2'd1), writeAddr(2'd0)), 4'hF, 4'h0);
        idle(3, 4'hF, 4'h0);
        compareCredits(2'd0, commits[0], ioPredPkg::creditMax);
        idle(3, 4'hF, 4'b0001);
    endtask

    task automatic readRuleTest();
        repeat (2) step(1'b1, makeInstr(ioPredPkg::opLoad, readAddr(2'd3), 10'h0), 4'hF, 4'h0);
        step(1'b1, makeInstr(ioPredPkg::opLoad, readAddr(2'd0), 10'h0), 4'hF, 4'h0);
        step(1'b1, makeInstr(ioPredPkg::opLoad, readAddr(2'd1), 10'h0), 4'hF, 4'h0);
        idle(3, 4'hF, 4'h0);
    endtask

    // Mostly full read ports, sparse credit returns, three in four slots used
    task automatic randomTest();
        logic [31:0] r;
        ioPredPkg::instr_t ins;
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            ins = makeInstr(ioPredPkg::opcode_e'(r[1:0]), randomAddr(), randomAddr());
            step(r[2] | r[3], ins, r[7:4] | r[11:8], r[15:12] & r[19:16]);
        end
        idle(3, 4'hF, 4'h0);
    endtask

    // ----------------------------------------
    // Run control
    // ----------------------------------------

    initial begin
        instrValid = 1'b0;
        instr = '0;
        readNotEmpty = '0;
        creditReturn = '0;
        errors = 0;
        checks = 0;
        seed = 32'h6566aa3e;
        pipeValid = '0;
        for (int i = 0; i < 3; i++) begin
            pipeInstr[i] = '0;
        end
        // Empty slots come out annulled since ioReady is low
        expected = '0;
        expected.annul = 1'b1;
        for (int p = 0; p < ioPredPkg::writePortCount; p++) begin
            credits[p] = ioPredPkg::creditMax;
            commits[p] = '0;
        end
        @(negedge reset);
        nonIoTest();
        loadTest();
        storeTest();
        moveTest();
        readRuleTest();
        randomTest();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #((testSteps + marginSteps) * 10);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- ioPredication.f
ioPredPkg.sv
ioCheck.sv
ioReadPredication.sv
ioWritePredication.sv
writeCreditTracker.sv
ioControl.sv
ioPredication.sv
clockGen.sv
ioPredicationChk.sv
ioPredicationTb.sv

//--- Makefile
TOP := ioPredicationTb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

obj_dir/V$(TOP): ioPredication.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f ioPredication.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f ioPredication.f

clean:
	rm -rf obj_dir $(LOG)
